// ==== logic/led_panel_defines.svh ====
`ifndef LED_PANEL_DEFINES_SVH
`define LED_PANEL_DEFINES_SVH

// scan geometry
`define LP_FRAME_BITS       10
`define LP_SUBFRAME_BITS    8   // one pwm level per subframe
`define LP_ADDR_BITS        5   // 32 row pairs
`define LP_COL_BITS         6   // 64 columns

// painter answers this many cycles after the position is published
`define LP_PAINT_DELAY      1

// fm6126 configuration words, shifted msb first
`define LP_FM_REG1          16'h7FFF
`define LP_FM_REG2          16'h0040

// latch window lengths in columns, counted from the end of the word stream
`define LP_FM_LATCH1        11
`define LP_FM_LATCH2        12

`endif

// ==== logic/led_panel_pkg.sv ====
`include "led_panel_defines.svh"

package led_panel_pkg;

    // position the painter is asked for
    typedef struct packed {
        logic [`LP_FRAME_BITS-1:0]    frame;
        logic [`LP_SUBFRAME_BITS-1:0] subframe;
        logic [`LP_ADDR_BITS-1:0]     row_addr;
        logic [`LP_COL_BITS-1:0]      col;
    } scan_pos_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb24_t;

    typedef struct packed {
        rgb24_t upper;  // rows 0..31
        rgb24_t lower;  // rows 32..63
    } pixel_pair_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb3_t;

    // panel pins, single rate
    typedef struct packed {
        rgb3_t                    rgb_upper;
        rgb3_t                    rgb_lower;
        logic [`LP_ADDR_BITS-1:0] addr;
        logic                     blank;
        logic                     latch;
        logic                     sclk;   // high when a column is presented
    } hub75_t;

    typedef enum logic [2:0] {
        INIT_START,
        INIT_REG1,
        INIT_REG1_END,
        INIT_REG2,
        INIT_REG2_END,
        INIT_DONE
    } init_state_e;

    typedef enum logic [2:0] {
        SCAN_INIT,
        SCAN_START_DELAY,
        SCAN_SHIFT_FIRST,
        SCAN_SHIFT,
        SCAN_SHIFT_LAST,
        SCAN_BLANK,
        SCAN_UNBLANK
    } scan_state_e;

    typedef enum logic [1:0] {
        CNT_COUNT,
        CNT_WAIT1,
        CNT_WAIT2
    } count_state_e;

endpackage

// ==== logic/scan_counter.sv ====
`timescale 1ns/10ps
`include "led_panel_defines.svh"

module scan_counter
    import led_panel_pkg::*;
(
    input  logic      clk,
    input  logic      pll_locked,
    input  logic      init_done,
    output scan_pos_t scan_pos
);

    localparam int SB = `LP_SUBFRAME_BITS;
    localparam logic [SB-1:0] LAST_SUBFRAME = SB'((1 << SB) - 2);   // 255 never shown
    localparam logic [`LP_ADDR_BITS-1:0] LAST_ROW = '1;
    localparam logic [`LP_COL_BITS-1:0]  LAST_COL = '1;

    count_state_e state;

    always_ff @(posedge clk or negedge pll_locked)
    begin
        if (!pll_locked)
        begin
            scan_pos <= '0;
            state    <= CNT_COUNT;
        end
        else if (!init_done)
        begin
            // parked at the origin while the driver registers are written
            scan_pos <= '0;
            state    <= CNT_COUNT;
        end
        else
        begin
            case (state)
                CNT_COUNT:
                begin
                    if (scan_pos.col == LAST_COL)
                    begin
                        scan_pos.col <= '0;
                        state        <= CNT_WAIT1;  // row done, room for blank and latch
                        if (scan_pos.row_addr == LAST_ROW)
                        begin
                            scan_pos.row_addr <= '0;
                            // early wrap gives 255 levels per frame
                            if (scan_pos.subframe == LAST_SUBFRAME)
                            begin
                                scan_pos.subframe <= '0;
                                scan_pos.frame    <= scan_pos.frame + 1'b1;
                            end
                            else
                                scan_pos.subframe <= scan_pos.subframe + 1'b1;
                        end
                        else
                            scan_pos.row_addr <= scan_pos.row_addr + 1'b1;
                    end
                    else
                        scan_pos.col <= scan_pos.col + 1'b1;
                end
                CNT_WAIT1: state <= CNT_WAIT2;
                CNT_WAIT2: state <= CNT_COUNT;
                default:   state <= CNT_COUNT;
            endcase
        end
    end

    subframe_skip_a: assert property (@(posedge clk) disable iff (!pll_locked)
        scan_pos.subframe != '1)
        else $error("subframe reached 255");

endmodule

// ==== logic/bit_plane_slicer.sv ====
`timescale 1ns/10ps
`include "led_panel_defines.svh"

module bit_plane_slicer
    import led_panel_pkg::*;
(
    input  logic                         clk,
    input  logic                         pll_locked,
    input  logic [`LP_SUBFRAME_BITS-1:0] subframe,
    input  pixel_pair_t                  pixel_color,
    output rgb3_t                        plane_upper,
    output rgb3_t                        plane_lower
);

    localparam int SB = `LP_SUBFRAME_BITS;

    logic [SB-1:0] sub_dly [`LP_PAINT_DELAY];  // follows the painter latency
    logic [SB-1:0] threshold;

    function automatic rgb3_t slice(input rgb24_t color, input logic [SB-1:0] level);
        rgb3_t bits;
        bits.r = color.r > level;
        bits.g = color.g > level;
        bits.b = color.b > level;
        return bits;
    endfunction

    always_ff @(posedge clk or negedge pll_locked)
    begin
        if (!pll_locked)
        begin
            for (int i = 0; i < `LP_PAINT_DELAY; i++)
                sub_dly[i] <= '0;
        end
        else
        begin
            sub_dly[0] <= subframe;
            for (int i = 1; i < `LP_PAINT_DELAY; i++)
                sub_dly[i] <= sub_dly[i-1];
        end
    end

    // reversed bit order spreads the on time, so flicker is faster
    always_comb
    begin
        for (int i = 0; i < SB; i++)
            threshold[i] = sub_dly[`LP_PAINT_DELAY-1][SB-1-i];
    end

    assign plane_upper = slice(pixel_color.upper, threshold);
    assign plane_lower = slice(pixel_color.lower, threshold);

endmodule

// ==== logic/fm6126_init.sv ====
`timescale 1ns/10ps
`include "led_panel_defines.svh"

module fm6126_init
    import led_panel_pkg::*;
(
    input  logic   clk,
    input  logic   pll_locked,
    output hub75_t init_panel,
    output logic   init_done
);

    localparam int CB = `LP_COL_BITS;
    localparam logic [CB-1:0] LAST_COL     = '1;
    localparam logic [CB-1:0] LATCH1_START = CB'((1 << CB) - `LP_FM_LATCH1);
    localparam logic [CB-1:0] LATCH2_START = CB'((1 << CB) - `LP_FM_LATCH2);

    init_state_e   state;
    logic [15:0]   shreg;       // rotates, back to the start word after 64 bits
    logic [CB-1:0] latch_cnt;   // latch opens when this reaches zero
    logic [CB-1:0] col;

    always_ff @(posedge clk or negedge pll_locked)
    begin
        if (!pll_locked)
        begin
            state            <= INIT_START;
            shreg            <= '0;
            latch_cnt        <= '0;
            col              <= '0;
            init_done        <= 1'b0;
            init_panel       <= '0;
            init_panel.blank <= 1'b1;
        end
        else
        begin
            case (state)
                INIT_START:
                begin
                    shreg     <= `LP_FM_REG1;
                    latch_cnt <= LATCH1_START;
                    col       <= '0;
                    state     <= INIT_REG1;
                end
                INIT_REG1, INIT_REG2:
                begin
                    // same bit on every colour line, every driver chip gets the word
                    init_panel.rgb_upper <= {3{shreg[15]}};
                    init_panel.rgb_lower <= {3{shreg[15]}};
                    init_panel.sclk      <= 1'b1;
                    init_panel.latch     <= (latch_cnt == '0);
                    shreg                <= {shreg[14:0], shreg[15]};
                    col                  <= col + 1'b1;
                    if (latch_cnt != '0)
                        latch_cnt <= latch_cnt - 1'b1;
                    if (col == LAST_COL)
                    begin
                        if (state == INIT_REG1)
                            state <= INIT_REG1_END;
                        else
                            state <= INIT_REG2_END;
                    end
                end
                INIT_REG1_END:
                begin
                    init_panel.sclk  <= 1'b0;
                    init_panel.latch <= 1'b0;
                    shreg            <= `LP_FM_REG2;
                    latch_cnt        <= LATCH2_START;
                    state            <= INIT_REG2;
                end
                INIT_REG2_END:
                begin
                    init_panel.sclk  <= 1'b0;
                    init_panel.latch <= 1'b0;
                    state            <= INIT_DONE;
                end
                INIT_DONE: init_done <= 1'b1;   // rises after the idle cycle
                default:   state <= INIT_START;
            endcase
        end
    end

    init_done_sticky_a: assert property (@(posedge clk) disable iff (!pll_locked)
        init_done |=> init_done)
        else $error("init_done dropped without reset");

endmodule

// ==== logic/row_scanner.sv ====
`timescale 1ns/10ps
`include "led_panel_defines.svh"

module row_scanner
    import led_panel_pkg::*;
(
    input  logic   clk,
    input  logic   pll_locked,
    input  logic   init_done,
    input  hub75_t init_panel,
    input  rgb3_t  plane_upper,
    input  rgb3_t  plane_lower,
    output hub75_t panel
);

    localparam int CB = `LP_COL_BITS;
    localparam int DB = $clog2(`LP_PAINT_DELAY + 1);
    localparam logic [DB-1:0] DELAY_START    = DB'(`LP_PAINT_DELAY - 1);
    localparam logic [CB-1:0] SHIFT_LAST_COL = CB'((1 << CB) - 2);   // last col comes next

    scan_state_e              state;
    logic [DB-1:0]            delay_cnt;
    logic [CB-1:0]            col;
    logic [`LP_ADDR_BITS-1:0] row;

    always_ff @(posedge clk or negedge pll_locked)
    begin
        if (!pll_locked)
        begin
            state       <= SCAN_INIT;
            delay_cnt   <= DELAY_START;
            col         <= '0;
            row         <= '0;
            panel       <= '0;
            panel.blank <= 1'b1;
        end
        else
        begin
            case (state)
                SCAN_INIT:
                begin
                    panel <= init_panel;    // sequencer owns the pins until done
                    if (init_done)
                    begin
                        // scan_counter starts now, wait for the first colour
                        if (delay_cnt == '0)
                            state <= SCAN_SHIFT_FIRST;
                        else
                        begin
                            delay_cnt <= delay_cnt - 1'b1;
                            state     <= SCAN_START_DELAY;
                        end
                    end
                end
                SCAN_START_DELAY:
                begin
                    if (delay_cnt == '0)
                        state <= SCAN_SHIFT_FIRST;
                    else
                        delay_cnt <= delay_cnt - 1'b1;
                end
                SCAN_SHIFT_FIRST, SCAN_SHIFT, SCAN_SHIFT_LAST:
                begin
                    panel.rgb_upper <= plane_upper;
                    panel.rgb_lower <= plane_lower;
                    panel.sclk      <= 1'b1;
                    col             <= col + 1'b1;  // wraps to 0 after the last one
                    if (state == SCAN_SHIFT_LAST)
                        state <= SCAN_BLANK;
                    else if (col == SHIFT_LAST_COL)
                        state <= SCAN_SHIFT_LAST;
                    else
                        state <= SCAN_SHIFT;
                end
                SCAN_BLANK:
                begin
                    // shift register full, move it to the output stage
                    panel.sclk  <= 1'b0;
                    panel.blank <= 1'b1;
                    panel.latch <= 1'b1;
                    state       <= SCAN_UNBLANK;
                end
                SCAN_UNBLANK:
                begin
                    panel.latch <= 1'b0;
                    panel.blank <= 1'b0;
                    panel.addr  <= row;         // row just latched
                    row         <= row + 1'b1;
                    state       <= SCAN_SHIFT_FIRST;
                end
                default: state <= SCAN_INIT;
            endcase
        end
    end

    // the fm6126 register writes hold latch with sclk, so only checked after init
    latch_sclk_a: assert property (@(posedge clk) disable iff (!pll_locked)
        init_done |-> !(panel.latch && panel.sclk))
        else $error("latch and sclk high together");

    latch_blank_a: assert property (@(posedge clk) disable iff (!pll_locked)
        panel.latch |-> panel.blank)
        else $error("latch without blank");

endmodule

// ==== logic/led_panel_top.sv ====
`timescale 1ns/10ps

module led_panel_top
    import led_panel_pkg::*;
(
    input  logic        clk,
    input  logic        pll_locked,
    input  pixel_pair_t pixel_color,
    output scan_pos_t   scan_pos,
    output hub75_t      panel
);

    hub75_t init_panel;
    logic   init_done;
    rgb3_t  plane_upper;
    rgb3_t  plane_lower;

    // driver chip configuration after power-up
    fm6126_init init_i
    (
        .clk        (clk),
        .pll_locked (pll_locked),
        .init_panel (init_panel),
        .init_done  (init_done)
    );

    // position sent to the external painter
    scan_counter counter_i
    (
        .clk        (clk),
        .pll_locked (pll_locked),
        .init_done  (init_done),
        .scan_pos   (scan_pos)
    );

    bit_plane_slicer slicer_i
    (
        .clk         (clk),
        .pll_locked  (pll_locked),
        .subframe    (scan_pos.subframe),
        .pixel_color (pixel_color),
        .plane_upper (plane_upper),
        .plane_lower (plane_lower)
    );

    row_scanner scanner_i
    (
        .clk         (clk),
        .pll_locked  (pll_locked),
        .init_done   (init_done),
        .init_panel  (init_panel),
        .plane_upper (plane_upper),
        .plane_lower (plane_lower),
        .panel       (panel)
    );

endmodule

// ==== sim/tb_led_panel.sv ====
`timescale 1ns/10ps
`include "led_panel_defines.svh"

module tb_led_panel
    import led_panel_pkg::*;
();

    localparam int N_ENTRIES  = 6;
    localparam int CLK_NS     = 8;
    localparam int COLS       = 1 << `LP_COL_BITS;
    localparam int ROWS       = 1 << `LP_ADDR_BITS;
    localparam int ROW_CYCLES = COLS + 2;   // 64 shift cycles plus latch and unblank
    localparam int LAST_SUB   = (1 << `LP_SUBFRAME_BITS) - 2;
    localparam int AB         = `LP_ADDR_BITS;
    localparam hub75_t CTRL_MASK = '{rgb_upper: '0, rgb_lower: '0, addr: '1,
                                     blank: 1'b1, latch: 1'b1, sclk: 1'b1};

    logic        clk         = 1'b0;
    logic        pll_locked  = 1'b0;
    pixel_pair_t pixel_color = '0;
    scan_pos_t   scan_pos;
    hub75_t      panel;

    rgb24_t tab_upper [N_ENTRIES];
    rgb24_t tab_lower [N_ENTRIES];
    int     tab_rows  [N_ENTRIES];
    logic   table_ready = 1'b0;

    int        errors    = 0;
    int        tests_run = 0;
    int        tests_ok  = 0;
    int        abs_row   = 0;   // panel rows checked so far
    scan_pos_t paint_hist [`LP_PAINT_DELAY] = '{default: '0};
    scan_pos_t pos_model   = '0;
    int        pos_wait    = 0;
    logic      pos_started = 1'b0;
    logic      wrap_seen   = 1'b0;

    led_panel_top dut_i
    (
        .clk         (clk),
        .pll_locked  (pll_locked),
        .pixel_color (pixel_color),
        .scan_pos    (scan_pos),
        .panel       (panel)
    );

    initial
    begin
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [7:0] reverse_bits(input logic [7:0] v);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
            r[i] = v[7-i];
        return r;
    endfunction

    // a channel is lit when it exceeds the reversed subframe
    function automatic rgb3_t expect_bits(input rgb24_t c, input logic [7:0] level);
        rgb3_t e;
        e.r = (c.r > level);
        e.g = (c.g > level);
        e.b = (c.b > level);
        return e;
    endfunction

    function automatic int entry_for_row(input int row);
        int acc;
        acc = 0;
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            acc += tab_rows[i];
            if (row < acc)
                return i;
        end
        return N_ENTRIES - 1;
    endfunction

    function automatic pixel_pair_t paint(input scan_pos_t p);
        pixel_pair_t pp;
        int          row;
        row = (int'(p.frame) * (LAST_SUB + 1) + int'(p.subframe)) * ROWS + int'(p.row_addr);
        pp.upper   = tab_upper[entry_for_row(row)];
        pp.lower   = tab_lower[entry_for_row(row)];
        pp.upper.r = {p.col, 2'b00};   // red ramp across the row
        return pp;
    endfunction

    // painter model answers LP_PAINT_DELAY cycles after the position
    always @(negedge clk)
    begin
        pixel_color <= paint(paint_hist[`LP_PAINT_DELAY-1]);
        for (int i = `LP_PAINT_DELAY - 1; i > 0; i--)
            paint_hist[i] <= paint_hist[i-1];
        paint_hist[0] <= scan_pos;
    end

    function automatic string panel_fields(input hub75_t p);
        return $sformatf("blank %b latch %b sclk %b addr %0d rgb %b %b",
                         p.blank, p.latch, p.sclk, p.addr, p.rgb_upper, p.rgb_lower);
    endfunction

    task automatic check_panel(input hub75_t got, input hub75_t exp, input hub75_t mask,
                               input string what);
        if ((got & mask) !== (exp & mask))
        begin
            errors++;
            $display("[FAIL] %0t: %s, got %s, expected %s", $time, what,
                     panel_fields(got), panel_fields(exp));
        end
    endtask

    task automatic check_pos(input scan_pos_t got, input scan_pos_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t: %s, got f/s/r/c %0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d",
                     $time, what, got.frame, got.subframe, got.row_addr, got.col,
                     exp.frame, exp.subframe, exp.row_addr, exp.col);
        end
    endtask

    task automatic check_rgb3(input rgb3_t got, input rgb3_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t: %s, got rgb %b expected %b", $time, what, got, exp);
        end
    endtask

    // scan position model of 64 columns and a 2 cycle hold
    task automatic step_pos_model();
        if (pos_wait > 0)
            pos_wait--;
        else if (pos_model.col != '1)
            pos_model.col = pos_model.col + 1'b1;
        else
        begin
            pos_model.col = '0;
            pos_wait      = 2;
            if (pos_model.row_addr != '1)
                pos_model.row_addr = pos_model.row_addr + 1'b1;
            else
            begin
                pos_model.row_addr = '0;
                if (int'(pos_model.subframe) == LAST_SUB)
                begin
                    pos_model.subframe = '0;
                    pos_model.frame    = pos_model.frame + 1'b1;
                    wrap_seen          = 1'b1;
                end
                else
                    pos_model.subframe = pos_model.subframe + 1'b1;
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (pll_locked && (pos_started || scan_pos != '0))
        begin
            pos_started = 1'b1;
            step_pos_model();
            check_pos(scan_pos, pos_model, "scan position");
            if (scan_pos !== pos_model)
                pos_model = scan_pos;   // carry on from the dut position after a slip
        end
    end

    task automatic fill_table();
        tab_upper[0] = '{r: 8'h00, g: 8'h00, b: 8'h00};
        tab_lower[0] = '{r: 8'hff, g: 8'hff, b: 8'hff};
        tab_rows[0]  = 40;
        tab_upper[1] = '{r: 8'h00, g: 8'h80, b: 8'h01};
        tab_lower[1] = '{r: 8'h7f, g: 8'h40, b: 8'hc0};
        tab_rows[1]  = 24;
        for (int i = 2; i < N_ENTRIES; i++)
        begin
            tab_upper[i] = 24'($urandom);
            tab_lower[i] = 24'($urandom);
            tab_rows[i]  = 32 + 4 * i;
        end
    endtask

    task automatic wait_sclk(input int max_cycles, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!panel.sclk && n < max_cycles)
        begin
            @(negedge clk);
            n++;
        end
        if (!panel.sclk)
        begin
            errors++;
            $display("%s: sclk did not start within %0d cycles", what, max_cycles);
        end
    endtask

    task automatic check_reset_state(input string what);
        hub75_t exp;
        exp       = '0;
        exp.blank = 1'b1;
        check_panel(panel, exp, '1, what);
        check_pos(scan_pos, '0, what);
    endtask

    task automatic check_init_word(input logic [15:0] word, input int latch_len,
                                   input bit wait_start, input string what);
        hub75_t exp;
        logic   b;
        if (wait_start)
            wait_sclk(16, what);
        else
            @(negedge clk);
        for (int k = 0; k < COLS; k++)
        begin
            if (k > 0)
                @(negedge clk);
            b             = word[15 - (k % 16)];   // msb first and rotating
            exp           = '0;
            exp.rgb_upper = {3{b}};
            exp.rgb_lower = {3{b}};
            exp.blank     = 1'b1;
            exp.sclk      = 1'b1;
            exp.latch     = (k >= COLS - latch_len);
            check_panel(panel, exp, '1, $sformatf("%s bit %0d", what, k));
        end
    endtask

    task automatic run_rows(input int idx);
        hub75_t        exp;
        rgb24_t        up;
        logic [7:0]    thr;
        logic [AB-1:0] prev_addr;
        for (int r = 0; r < tab_rows[idx]; r++)
        begin
            thr       = reverse_bits(8'((abs_row / ROWS) % (LAST_SUB + 1)));
            prev_addr = (abs_row == 0) ? '0 : AB'(abs_row - 1);
            if (abs_row == 0)
                wait_sclk(16, "first row");
            else
                @(negedge clk);
            for (int k = 0; k < COLS; k++)
            begin
                if (k > 0)
                    @(negedge clk);
                exp       = '0;
                exp.addr  = prev_addr;
                exp.blank = (abs_row == 0);   // first row shifts before any unblank
                exp.sclk  = 1'b1;
                check_panel(panel, exp, CTRL_MASK, $sformatf("shift row %0d", abs_row));
                up   = tab_upper[idx];
                up.r = 8'(k * 4);
                check_rgb3(panel.rgb_upper, expect_bits(up, thr),
                           $sformatf("upper half row %0d col %0d", abs_row, k));
                check_rgb3(panel.rgb_lower, expect_bits(tab_lower[idx], thr),
                           $sformatf("lower half row %0d col %0d", abs_row, k));
            end
            @(negedge clk);
            exp       = '0;
            exp.addr  = prev_addr;
            exp.blank = 1'b1;
            exp.latch = 1'b1;
            check_panel(panel, exp, CTRL_MASK, $sformatf("latch after row %0d", abs_row));
            @(negedge clk);
            exp      = '0;
            exp.addr = AB'(abs_row);
            check_panel(panel, exp, CTRL_MASK, $sformatf("unblank after row %0d", abs_row));
            abs_row++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start)
        begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, name);
        end
        else
            $display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - err_start);
    endtask

    initial
    begin
        int err_start;
        void'($urandom(32'h49da_7b04));
        fill_table();
        table_ready = 1'b1;

        err_start = errors;
        @(negedge clk);
        check_reset_state("during reset");
        @(negedge clk);
        check_reset_state("end of reset");
        pll_locked = 1'b1;
        @(negedge clk);
        check_reset_state("first cycle after reset");
        report_test("reset state", err_start);

        err_start = errors;
        check_init_word(`LP_FM_REG1, `LP_FM_LATCH1, 1'b1, "fm6126 reg1");
        @(negedge clk);
        check_panel(panel, '{default: '0, blank: 1'b1}, CTRL_MASK, "gap after reg1");
        check_init_word(`LP_FM_REG2, `LP_FM_LATCH2, 1'b0, "fm6126 reg2");
        @(negedge clk);
        check_panel(panel, '{default: '0, blank: 1'b1}, CTRL_MASK, "idle after reg2");
        report_test("fm6126 init", err_start);

        for (int t = 0; t < N_ENTRIES; t++)
        begin
            err_start = errors;
            run_rows(t);
            report_test($sformatf("rows of entry %0d", t), err_start);
        end

        // the position monitor checks the wrap while this waits for frame 1
        err_start = errors;
        wait (wrap_seen);
        repeat (ROW_CYCLES) @(negedge clk);
        report_test("subframe wrap", err_start);

        $display("%0d of %0d tests ok, %0d check errors", tests_ok, tests_run, errors);
        if (errors == 0 && tests_ok == tests_run)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        longint limit;
        wait (table_ready);
        limit = 130 + longint'(LAST_SUB + 1) * ROWS * ROW_CYCLES + 1000;   // init plus a frame
        for (int i = 0; i < N_ENTRIES; i++)
            limit += tab_rows[i] * ROW_CYCLES;
        #(limit * CLK_NS);
        $display("timeout: scan did not finish");
        $display("tests failed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+logic
logic/led_panel_pkg.sv
logic/scan_counter.sv
logic/bit_plane_slicer.sv
logic/fm6126_init.sv
logic/row_scanner.sv
logic/led_panel_top.sv
sim/tb_led_panel.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the led panel testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_led_panel -Mdir obj_dir

./obj_dir/Vtb_led_panel | tee sim.log

if grep -q "all tests passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported a failure"
    exit 1
fi
